//--- dtim.f
+incdir+rtl
rtl/dtimPkg.sv
rtl/dtimLaneIf.sv
rtl/dtimIssue.sv
rtl/dtimBank.sv
rtl/dtimReadAlign.sv
rtl/dtim.sv
tests/dtimChecker.sv
tests/dtimTb.sv

//--- rtl/dtim.sv
// DTIM top level joining the issue block, four byte banks and read alignment
`include "dtim_cfg.svh"

module dtim (
  input  logic        clk,
  input  logic        reset,
  input  logic        cpuBusy,
  input  logic        trapM,
  input  logic [1:0]  memRW,
  input  logic [31:0] adrE,
  input  logic [31:0] adrM,
  input  logic [2:0]  funct3M,
  input  logic [31:0] writeDataM,
  output logic [31:0] readDataM
);
  import dtimPkg::*;

  // One lane bundle per byte bank
  dtimLaneIf laneBus [`DTIM_LANES-1:0] ();

  ////////////////////
  // Issue
  ////////////////////

  // Address select, byte strobes and store data replication
  dtimIssue issue (
    .memRW      (rwT'(memRW)),
    .cpuBusy    (cpuBusy),
    .trapM      (trapM),
    .adrE       (adrE),
    .adrM       (adrM),
    .funct3M    (funct3M),
    .writeDataM (writeDataM),
    .lanes      (laneBus)
  );

  ////////////////////
  // Banks
  ////////////////////

  // Identical byte banks, one per lane
  for (genvar i = 0; i < `DTIM_LANES; i++) begin : gBank
    dtimBank bank (
      .clk   (clk),
      .reset (reset),
      .lane  (laneBus[i])
    );
  end

  // Load result is formed from the bank registers and the M-stage fields
  dtimReadAlign readAlign (
    .adrM      (adrM),
    .funct3M   (funct3M),
    .lanes     (laneBus),
    .readDataM (readDataM)
  );

  // A misaligned load would span two words, which the banks cannot return in one cycle
  // Only the top sees both the access type and the address seen by read alignment
  loadAligned: assert property (@(posedge clk) disable iff (reset)
    (memRW == rwRead) |->
      ((funct3M[1:0] == sizeHalf) ? (adrM[0] == 1'b0) :
       (funct3M[1:0] == sizeWord) ? (adrM[1:0] == 2'b00) : 1'b1))
    else $error("dtim: misaligned load at address %h", adrM);

endmodule

//--- rtl/dtimBank.sv
// DTIM byte bank with synchronous write and one cycle of registered read latency
`include "dtim_cfg.svh"

module dtimBank (
  input logic     clk,
  input logic     reset,
  dtimLaneIf.bank lane
);

  // Contents are undefined after reset, only the read register is cleared
  logic [7:0] mem [`DTIM_WORDS];

  ////////////////////
  // Write port
  ////////////////////

  // Store lands at the edge that ends the memory stage
  always_ff @(posedge clk) begin
    if (lane.we) begin
      mem[lane.adr] <= lane.wd;
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Read every cycle, a write to the same word returns the old byte
  always_ff @(posedge clk) begin
    if (reset) begin
      lane.rd <= '0;
    end else begin
      lane.rd <= mem[lane.adr];
    end
  end

  // An unknown strobe would corrupt the bank silently
  weKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(lane.we))
    else $error("dtimBank: write strobe is unknown");

endmodule

//--- rtl/dtimIssue.sv
// DTIM issue block selecting the bank address and building per-lane write strobes and data
`include "dtim_cfg.svh"

module dtimIssue (
  input  dtimPkg::rwT   memRW,
  input  logic          cpuBusy,
  input  logic          trapM,
  input  dtimPkg::adrT  adrE,
  input  dtimPkg::adrT  adrM,
  input  logic [2:0]    funct3M,
  input  dtimPkg::wordT writeDataM,
  dtimLaneIf.issue      lanes [`DTIM_LANES-1:0]
);
  import dtimPkg::*;

  // Number of byte-offset bits below the word address
  localparam int OffBits = $clog2(`DTIM_LANES);

  logic                   useM;
  logic                   storeM;
  adrT                    adrSel;
  wordAdrT                wordAdr;
  logic [`DTIM_LANES-1:0] sizeMask;
  logic [`DTIM_LANES-1:0] byteEn;
  wordT                   wdRep;

  ////////////////////
  // Address select
  ////////////////////

  // A held pipeline or a store needs the memory-stage address
  // Otherwise the next load is fetched early from the execute stage
  assign useM    = cpuBusy | (memRW == rwWrite);
  assign adrSel  = useM ? adrM : adrE;
  assign wordAdr = adrSel[OffBits +: $bits(wordAdrT)];

  ////////////////////
  // Byte enables
  ////////////////////

  // Mask of lanes covered by the access before the offset is applied
  always_comb begin
    case (sizeE'(funct3M[1:0]))
      sizeByte: sizeMask = `DTIM_LANES'('b1);
      sizeHalf: sizeMask = `DTIM_LANES'('b11);
      default:  sizeMask = '1;
    endcase
  end

  // Alignment is guaranteed, so a plain shift places the mask on the addressed lanes
  assign byteEn = sizeMask << adrM[OffBits-1:0];

  // A pending trap in M squashes the store
  assign storeM = (memRW == rwWrite) & ~trapM;

  ////////////////////
  // Store data
  ////////////////////

  // Copy narrow data into every lane so the enabled lane always finds its byte
  always_comb begin
    case (sizeE'(funct3M[1:0]))
      sizeByte: wdRep = {`DTIM_LANES{writeDataM[7:0]}};
      sizeHalf: wdRep = {(`DTIM_LANES / 2){writeDataM[15:0]}};
      default:  wdRep = writeDataM;
    endcase
  end

  // Fan the shared address and the lane-specific strobe and byte out to each bank
  for (genvar i = 0; i < `DTIM_LANES; i++) begin : gLane
    assign lanes[i].adr = wordAdr;
    assign lanes[i].we  = storeM & byteEn[i];
    assign lanes[i].wd  = wdRep[8*i +: 8];
  end

  // The 11 access code has no meaning for this memory
  // Checked once the inputs have settled in each time step
  illegalRw: assert final (memRW !== 2'b11)
    else $error("dtimIssue: illegal access code 11 on memRW");

endmodule

//--- rtl/dtimLaneIf.sv
// DTIM lane interface carrying one byte lane from issue to bank to read alignment
interface dtimLaneIf;
  import dtimPkg::*;

  // Word address shared by all lanes, driven once per lane by the issue block
  wordAdrT    adr;

  // Write strobe for this lane only
  logic       we;

  // Store byte already moved into this lane's position
  logic [7:0] wd;

  // Registered read byte from the bank
  logic [7:0] rd;

  // Issue side sets up the access
  modport issue (output adr, we, wd);

  // The bank performs the access and returns the read byte
  modport bank (input adr, we, wd, output rd);

  // Read alignment only looks at the returned byte
  modport align (input rd);

endinterface

//--- rtl/dtimPkg.sv
// DTIM package with the access code, access size and address and data types
`include "dtim_cfg.svh"

package dtimPkg;

  ////////////////////
  // Access encodings
  ////////////////////

  // Memory-stage access type from the load/store unit
  // Code 11 never occurs and is caught by an assertion in the issue block
  typedef enum logic [1:0] {
    rwNone  = 2'b00,
    rwWrite = 2'b01,
    rwRead  = 2'b10
  } rwT;

  // Access size taken straight from funct3 bits 1:0
  // Bit 2 of funct3 carries the unsigned flag and is handled separately
  typedef enum logic [1:0] {
    sizeByte = 2'd0,
    sizeHalf = 2'd1,
    sizeWord = 2'd2
  } sizeE;

  ////////////////////
  // Data and address
  ////////////////////

  // One full data word as seen by the core
  typedef logic [`DTIM_XLEN-1:0] wordT;

  // Byte address from the execute or memory stage
  typedef logic [`DTIM_XLEN-1:0] adrT;

  // Word address inside one bank
  typedef logic [$clog2(`DTIM_WORDS)-1:0] wordAdrT;

endpackage

//--- rtl/dtimReadAlign.sv
// DTIM read alignment assembling the bank bytes and extending the addressed load
`include "dtim_cfg.svh"

module dtimReadAlign (
  input  dtimPkg::adrT  adrM,
  input  logic [2:0]    funct3M,
  dtimLaneIf.align      lanes [`DTIM_LANES-1:0],
  output dtimPkg::wordT readDataM
);
  import dtimPkg::*;

  // Number of byte-offset bits below the word address
  localparam int OffBits = $clog2(`DTIM_LANES);

  wordT rawWord;
  wordT shifted;
  logic signExt;

  ////////////////////
  // Word assembly
  ////////////////////

  // Lane zero holds the least significant byte
  for (genvar i = 0; i < `DTIM_LANES; i++) begin : gLane
    assign rawWord[8*i +: 8] = lanes[i].rd;
  end

  // Move the addressed byte or halfword down to bit zero
  assign shifted = rawWord >> {adrM[OffBits-1:0], 3'b000};

  ////////////////////
  // Extension
  ////////////////////

  // lbu and lhu set funct3 bit 2, the others sign-extend
  assign signExt = ~funct3M[2];

  always_comb begin
    case (sizeE'(funct3M[1:0]))
      sizeByte: readDataM = {{(`DTIM_XLEN - 8){signExt & shifted[7]}}, shifted[7:0]};
      sizeHalf: readDataM = {{(`DTIM_XLEN - 16){signExt & shifted[15]}}, shifted[15:0]};
      // Word loads need neither shift nor extension
      default:  readDataM = rawWord;
    endcase
  end

endmodule

//--- rtl/dtim_cfg.svh
// DTIM configuration macros for word width, bank depth and lane count
`ifndef DTIM_CFG_SVH
`define DTIM_CFG_SVH

////////////////////
// Data path
////////////////////

// Width of a load or store word in bits
`define DTIM_XLEN 32

// Every lane holds one byte of the word
`define DTIM_LANES (`DTIM_XLEN / 8)

////////////////////
// Storage
////////////////////

// Depth of each byte bank in words, which gives 8 word-address bits
`define DTIM_WORDS 256

`endif

//--- tests/dtimChecker.sv
// DTIM checker that mirrors stores in a shadow memory and compares every load result
module dtimChecker (
  input  logic          clk,
  input  logic          reset,
  input  logic          cpuBusy,
  input  logic          trapM,
  input  logic [1:0]    memRW,
  input  dtimPkg::adrT  adrM,
  input  logic [2:0]    funct3M,
  input  dtimPkg::wordT writeDataM,
  input  dtimPkg::wordT readDataM,
  output int            errCount,
  output int            checkCount
);
  import dtimPkg::*;

  // Shadow depth matches the bank depth, so the word index is adrM[9:2]
  localparam int ShadowWords = 256;
  localparam int IdxBits     = $clog2(ShadowWords);

  wordT  shadow [ShadowWords];
  wordT  expected;

  // Set by the testbench top so error lines name the running test
  string testName = "idle";

  initial begin
    errCount   = 0;
    checkCount = 0;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Expected load value straight from the RISC-V load rules
  function automatic wordT refLoad(input adrT a, input logic [2:0] f3);
    wordT        w;
    logic [7:0]  b;
    logic [15:0] h;
    w = shadow[a[IdxBits+1:2]];
    b = w[8*a[1:0] +: 8];
    h = a[1] ? w[31:16] : w[15:0];
    case (f3)
      3'd0:    return {{24{b[7]}}, b};
      3'd4:    return {24'h0, b};
      3'd1:    return {{16{h[15]}}, h};
      3'd5:    return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // Merge a store into the shadow word, byte by byte
  // sb takes data bits 7:0, sh takes 15:0, sw takes the whole word
  task automatic applyStore(input adrT a, input logic [2:0] f3, input wordT d);
    int   idx;
    logic hit;
    idx = a[IdxBits+1:2];
    for (int i = 0; i < 4; i++) begin
      case (f3[1:0])
        2'd0:    hit = (i == a[1:0]);
        2'd1:    hit = ((i >> 1) == a[1]);
        default: hit = 1'b1;
      endcase
      if (hit) begin
        case (f3[1:0])
          2'd0:    shadow[idx][8*i +: 8] = d[7:0];
          2'd1:    shadow[idx][8*i +: 8] = d[8*(i%2) +: 8];
          default: shadow[idx][8*i +: 8] = d[8*i +: 8];
        endcase
      end
    end
  endtask

  ////////////////////
  // Compare
  ////////////////////

  // Inputs are stable at the rising edge, and readDataM still shows the
  // bank registers loaded at the previous edge, which is the M-stage result
  always @(posedge clk) begin
    if (!reset) begin
      if (memRW == rwRead) begin
        expected = refLoad(adrM, funct3M);
        checkCount++;
        if (readDataM !== expected) begin
          errCount++;
          $display("** Error %s: load at %h funct3 %0d busy %b expected %h actual %h",
                   testName, adrM, funct3M, cpuBusy, expected, readDataM);
        end
      end else if (memRW == rwWrite && !trapM) begin
        // Trapped stores never reach the shadow
        applyStore(adrM, funct3M, writeDataM);
      end
    end
  end

endmodule

//--- tests/dtimTb.sv
// DTIM testbench driving directed and random loads and stores into the top level
module dtimTb;
  import dtimPkg::*;

  // Longest wait for one falling clock edge, in time units
  localparam int EdgeTimeout = 20;

  logic        clk = 1'b0;
  logic        reset;
  logic        cpuBusy;
  logic        trapM;
  logic [1:0]  memRW;
  logic [31:0] adrE;
  logic [31:0] adrM;
  logic [2:0]  funct3M;
  logic [31:0] writeDataM;
  logic [31:0] readDataM;

  int          errTotal;
  int          checkTotal;
  int          errBase;
  int          checkBase;
  int          emptyTests = 0;
  int          fallCount  = 0;
  int unsigned lcgState   = 64860;

  ////////////////////
  // Clock and DUT
  ////////////////////

  always #4 clk = ~clk;

  // Counts falling edges so waits can poll with a timeout
  always @(negedge clk) fallCount++;

  dtim dut (
    .clk        (clk),
    .reset      (reset),
    .cpuBusy    (cpuBusy),
    .trapM      (trapM),
    .memRW      (memRW),
    .adrE       (adrE),
    .adrM       (adrM),
    .funct3M    (funct3M),
    .writeDataM (writeDataM),
    .readDataM  (readDataM)
  );

  dtimChecker chk (
    .clk        (clk),
    .reset      (reset),
    .cpuBusy    (cpuBusy),
    .trapM      (trapM),
    .memRW      (memRW),
    .adrM       (adrM),
    .funct3M    (funct3M),
    .writeDataM (writeDataM),
    .readDataM  (readDataM),
    .errCount   (errTotal),
    .checkCount (checkTotal)
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Numerical Recipes constants
  // The upper bits of the state are the useful ones
  function automatic int unsigned lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Random address aligned to the size in funct3
  function automatic adrT randAdr(input logic [2:0] f3);
    adrT a;
    a = lcgNext() >> 6;
    case (f3[1:0])
      2'd1:    a = a & ~32'h1;
      2'd2:    a = a & ~32'h3;
      default: a = a;
    endcase
    return a;
  endfunction

  // One of lb, lh, lw, lbu, lhu
  function automatic logic [2:0] randLoadF3();
    case ((lcgNext() >> 16) % 5)
      0:       return 3'd0;
      1:       return 3'd1;
      2:       return 3'd2;
      3:       return 3'd4;
      default: return 3'd5;
    endcase
  endfunction

  task automatic waitFall();
    int start;
    start = fallCount;
    for (int t = 0; t < EdgeTimeout && fallCount == start; t++) begin
      #1;
    end
    if (fallCount == start) begin
      $display("Timeout: the clock made no falling edge within %0d time units", EdgeTimeout);
      $display("SOME TESTS FAILED");
      $finish;
    end
  endtask

  // Drives the M-stage fields and the next E address for one cycle
  task automatic driveCycle(input rwT rw, input adrT aM, input logic [2:0] f3,
                            input wordT wd, input logic trap, input logic busy,
                            input adrT aE);
    memRW      = rw;
    adrM       = aM;
    funct3M    = f3;
    writeDataM = wd;
    trapM      = trap;
    cpuBusy    = busy;
    adrE       = aE;
    waitFall();
  endtask

  task automatic idleCycle();
    driveCycle(rwNone, '0, 3'd0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic storeAccess(input adrT a, input logic [2:0] f3, input wordT d,
                             input logic trap);
    driveCycle(rwWrite, a, f3, d, trap, 1'b0, '0);
  endtask

  // E cycle on an idle M stage, then the M cycle
  task automatic loadAccess(input adrT a, input logic [2:0] f3);
    driveCycle(rwNone, '0, 3'd0, '0, 1'b0, 1'b0, a);
    driveCycle(rwRead, a, f3, '0, 1'b0, 1'b0, '0);
  endtask

  // Second load's E cycle overlaps the first load's M cycle
  task automatic loadPair(input adrT a0, input logic [2:0] f0,
                          input adrT a1, input logic [2:0] f1);
    driveCycle(rwNone, '0, 3'd0, '0, 1'b0, 1'b0, a0);
    driveCycle(rwRead, a0, f0, '0, 1'b0, 1'b0, a1);
    driveCycle(rwRead, a1, f1, '0, 1'b0, 1'b0, '0);
  endtask

  // Busy cycles carry junk on adrE, which the banks must ignore
  task automatic busyLoad(input adrT a, input logic [2:0] f3, input int holdCycles);
    driveCycle(rwNone, '0, 3'd0, '0, 1'b0, 1'b0, a);
    for (int i = 0; i < holdCycles; i++) begin
      driveCycle(rwRead, a, f3, '0, 1'b0, 1'b1, lcgNext());
    end
    driveCycle(rwRead, a, f3, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic beginTest(input string name);
    chk.testName = name;
    errBase      = errTotal;
    checkBase    = checkTotal;
  endtask

  task automatic endTest(input string name);
    int errs;
    int checks;
    idleCycle();
    errs   = errTotal - errBase;
    checks = checkTotal - checkBase;
    if (checks == 0) begin
      $display("Test %s compared no loads at all", name);
      emptyTests++;
    end else begin
      $display("Test %s: %0d loads compared, %0d errors", name, checks, errs);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int done;
    logic [2:0] sz;
    logic [2:0] f0;
    logic [2:0] f1;
    reset      = 1'b1;
    cpuBusy    = 1'b0;
    trapM      = 1'b0;
    memRW      = 2'b00;
    adrE       = '0;
    adrM       = '0;
    funct3M    = 3'd0;
    writeDataM = '0;
    repeat (8) waitFall();
    reset = 1'b0;

    beginTest("wordRoundTrip");
    storeAccess(32'h100, 3'd2, 32'hCAFEF00D, 1'b0);
    storeAccess(32'h3FC, 3'd2, 32'h80000001, 1'b0);
    loadAccess(32'h100, 3'd2);
    loadAccess(32'h3FC, 3'd2);
    endTest("wordRoundTrip");

    // Upper bits of narrow store data are junk on purpose
    // Lane 1 keeps its byte from the word store
    beginTest("byteHalfMerge");
    storeAccess(32'h40, 3'd2, 32'h11223344, 1'b0);
    storeAccess(32'h42, 3'd1, 32'h5555F0E1, 1'b0);
    storeAccess(32'h40, 3'd0, 32'hDEADBE85, 1'b0);
    for (int i = 0; i < 4; i++) begin
      loadAccess(32'h40 + i, 3'd0);
      loadAccess(32'h40 + i, 3'd4);
    end
    loadPair(32'h40, 3'd1, 32'h42, 3'd5);
    loadPair(32'h42, 3'd1, 32'h40, 3'd5);
    loadAccess(32'h40, 3'd2);
    endTest("byteHalfMerge");

    beginTest("trapSquash");
    storeAccess(32'h80, 3'd2, 32'h12345678, 1'b0);
    storeAccess(32'h80, 3'd2, 32'hFFFFFFFF, 1'b1);
    storeAccess(32'h81, 3'd0, 32'h00000000, 1'b1);
    loadAccess(32'h80, 3'd2);
    loadAccess(32'h81, 3'd4);
    endTest("trapSquash");

    beginTest("busyHold");
    storeAccess(32'hC4, 3'd2, 32'h9ABC8DEF, 1'b0);
    busyLoad(32'hC4, 3'd2, 4);
    busyLoad(32'hC6, 3'd1, 3);
    endTest("busyHold");

    // Fill every word first so no random load sees an unwritten byte
    beginTest("randomMix");
    for (int w = 0; w < 256; w++) begin
      storeAccess(w * 4, 3'd2, lcgNext(), 1'b0);
    end
    done = 0;
    while (done < 200) begin
      case ((lcgNext() >> 16) % 3)
        0: begin
          sz = 3'((lcgNext() >> 16) % 3);
          storeAccess(randAdr(sz), sz, lcgNext(), ((lcgNext() >> 16) % 8) == 0);
          idleCycle();
          done++;
        end
        1: begin
          f0 = randLoadF3();
          loadAccess(randAdr(f0), f0);
          done++;
        end
        default: begin
          f0 = randLoadF3();
          f1 = randLoadF3();
          loadPair(randAdr(f0), f0, randAdr(f1), f1);
          done += 2;
        end
      endcase
    end
    endTest("randomMix");

    $display("Loads compared: %0d, errors: %0d, tests without comparisons: %0d",
             checkTotal, errTotal, emptyTests);
    if (errTotal == 0 && emptyTests == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
